// File: source/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_ID_W 8

// Instruction RAM window, one word per 4 bytes
`define IRAM_BASE 32'h0000_0000
`define IRAM_WORDS 256

// GPIO block, offset 0 output register, offset 4 pin inputs
`define GPIO_BASE 32'h4000_0000
`define GPIO_W 8

// System timer, offset 0 low word, offset 4 high word
`define TIMER_BASE 32'h4000_1000

// Window size of each peripheral
`define PERIPH_SPAN 32'h0000_1000

`endif

// File: source/soc_bus_pkg.sv
`include "soc_params.svh"

package soc_bus_pkg;

  // Request opcode
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // Same codes as the AXI xRESP field
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } bus_resp_e;

  // 1 + 8 + 32 + 32 = 73 bits
  typedef struct packed
  {
    bus_op_e                op;
    logic [`SOC_ID_W-1:0]   id;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  // 8 + 2 + 32 = 42 bits
  typedef struct packed
  {
    logic [`SOC_ID_W-1:0]   id;
    bus_resp_e              resp;
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

// File: source/soc_ctrl_pkg.sv
`include "soc_params.svh"

package soc_ctrl_pkg;

  // Target of a decoded address
  typedef enum logic [1:0]
  {
    SEL_IRAM  = 2'd0,
    SEL_GPIO  = 2'd1,
    SEL_TIMER = 2'd2,
    SEL_NONE  = 2'd3
  } slave_sel_e;

  // Decoder FSM
  typedef enum logic [1:0]
  {
    ST_IDLE  = 2'd0,
    ST_SLAVE = 2'd1,
    ST_RESP  = 2'd2
  } dec_state_e;

  // Word offset covers one 4 KB peripheral window
  typedef struct packed
  {
    soc_bus_pkg::bus_op_e   op;
    logic [9:0]             offset;
    logic [`SOC_DATA_W-1:0] wdata;
  } slv_req_t;

  typedef struct packed
  {
    soc_bus_pkg::bus_resp_e resp;
    logic [`SOC_DATA_W-1:0] rdata;
  } slv_rsp_t;

endpackage

// File: source/bus_decoder.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module bus_decoder (
  input  logic                   i_clk,
  input  logic                   i_rst_b,
  input  logic                   i_req_valid,
  output logic                   o_req_ready,
  input  soc_bus_pkg::bus_req_t  i_req,
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output soc_bus_pkg::bus_rsp_t  o_rsp,
  output soc_ctrl_pkg::slv_req_t o_slv_req,
  output logic                   o_iram_sel,
  output logic                   o_gpio_sel,
  output logic                   o_timer_sel,
  input  soc_ctrl_pkg::slv_rsp_t i_iram_rsp,
  input  soc_ctrl_pkg::slv_rsp_t i_gpio_rsp,
  input  soc_ctrl_pkg::slv_rsp_t i_timer_rsp,
  input  logic                   i_iram_rsp_valid,
  input  logic                   i_gpio_rsp_valid,
  input  logic                   i_timer_rsp_valid
);

  soc_ctrl_pkg::dec_state_e state_q;
  soc_ctrl_pkg::slave_sel_e sel_q;
  soc_ctrl_pkg::slave_sel_e dec_sel;
  soc_ctrl_pkg::slv_req_t   slv_req_q;
  soc_ctrl_pkg::slv_rsp_t   slv_rsp;
  soc_bus_pkg::bus_rsp_t    rsp_q;
  logic [`SOC_ADDR_W-1:0]   addr;
  logic [`SOC_ADDR_W-1:0]   rel_addr;
  logic [9:0]               dec_offset;
  logic                     req_fire;
  logic                     rsp_fire;
  logic                     slv_vld;
  logic                     iram_sel_q;
  logic                     gpio_sel_q;
  logic                     timer_sel_q;

  assign addr     = i_req.addr;
  assign req_fire = i_req_valid && o_req_ready;
  assign rsp_fire = o_rsp_valid && i_rsp_ready;

  // Address map, misaligned addresses fall through to SEL_NONE
  always_comb
  begin
    dec_sel  = soc_ctrl_pkg::SEL_NONE;
    rel_addr = '0;
    if (addr[1:0] == 2'b00)
    begin
      if (addr >= `IRAM_BASE && addr < `IRAM_BASE + `IRAM_WORDS * 4)
      begin
        dec_sel  = soc_ctrl_pkg::SEL_IRAM;
        rel_addr = addr - `IRAM_BASE;
      end
      else if (addr >= `GPIO_BASE && addr < `GPIO_BASE + `PERIPH_SPAN)
      begin
        dec_sel  = soc_ctrl_pkg::SEL_GPIO;
        rel_addr = addr - `GPIO_BASE;
      end
      else if (addr >= `TIMER_BASE && addr < `TIMER_BASE + `PERIPH_SPAN)
      begin
        dec_sel  = soc_ctrl_pkg::SEL_TIMER;
        rel_addr = addr - `TIMER_BASE;
      end
    end
    dec_offset = rel_addr[11:2];
  end

  // Return path from the slave picked at acceptance
  always_comb
  begin
    case (sel_q)
      soc_ctrl_pkg::SEL_IRAM:
      begin
        slv_vld = i_iram_rsp_valid;
        slv_rsp = i_iram_rsp;
      end
      soc_ctrl_pkg::SEL_GPIO:
      begin
        slv_vld = i_gpio_rsp_valid;
        slv_rsp = i_gpio_rsp;
      end
      soc_ctrl_pkg::SEL_TIMER:
      begin
        slv_vld = i_timer_rsp_valid;
        slv_rsp = i_timer_rsp;
      end
      default:
      begin
        slv_vld = 1'b0;
        slv_rsp = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_b)
  begin
    if (!i_rst_b)
    begin
      state_q     <= soc_ctrl_pkg::ST_IDLE;
      sel_q       <= soc_ctrl_pkg::SEL_NONE;
      iram_sel_q  <= 1'b0;
      gpio_sel_q  <= 1'b0;
      timer_sel_q <= 1'b0;
    end
    else
    begin
      // Strobes last a single cycle
      iram_sel_q  <= 1'b0;
      gpio_sel_q  <= 1'b0;
      timer_sel_q <= 1'b0;
      case (state_q)
        soc_ctrl_pkg::ST_IDLE:
        begin
          if (req_fire)
          begin
            sel_q <= dec_sel;
            if (dec_sel == soc_ctrl_pkg::SEL_NONE)
            begin
              state_q <= soc_ctrl_pkg::ST_RESP;
            end
            else
            begin
              state_q     <= soc_ctrl_pkg::ST_SLAVE;
              iram_sel_q  <= (dec_sel == soc_ctrl_pkg::SEL_IRAM);
              gpio_sel_q  <= (dec_sel == soc_ctrl_pkg::SEL_GPIO);
              timer_sel_q <= (dec_sel == soc_ctrl_pkg::SEL_TIMER);
            end
          end
        end
        soc_ctrl_pkg::ST_SLAVE:
        begin
          if (slv_vld)
          begin
            state_q <= soc_ctrl_pkg::ST_RESP;
          end
        end
        soc_ctrl_pkg::ST_RESP:
        begin
          if (rsp_fire)
          begin
            state_q <= soc_ctrl_pkg::ST_IDLE;
          end
        end
        default:
        begin
          state_q <= soc_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge i_clk)
  begin
    if (req_fire)
    begin
      slv_req_q.op     <= i_req.op;
      slv_req_q.offset <= dec_offset;
      slv_req_q.wdata  <= i_req.wdata;
      rsp_q.id         <= i_req.id;
      // Decode error unless a slave answers
      rsp_q.resp       <= soc_bus_pkg::RESP_DECERR;
      rsp_q.rdata      <= '0;
    end
    else if (state_q == soc_ctrl_pkg::ST_SLAVE && slv_vld)
    begin
      rsp_q.resp  <= slv_rsp.resp;
      rsp_q.rdata <= slv_rsp.rdata;
    end
  end

  assign o_req_ready = (state_q == soc_ctrl_pkg::ST_IDLE);
  assign o_rsp_valid = (state_q == soc_ctrl_pkg::ST_RESP);
  assign o_rsp       = rsp_q;
  assign o_slv_req   = slv_req_q;
  assign o_iram_sel  = iram_sel_q;
  assign o_gpio_sel  = gpio_sel_q;
  assign o_timer_sel = timer_sel_q;

  a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_b)
    $onehot0({o_iram_sel, o_gpio_sel, o_timer_sel}));

  a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_b)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp));

endmodule

// File: source/iram_slave.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module iram_slave (
  input  logic                   i_clk,
  input  logic                   i_sel,
  input  soc_ctrl_pkg::slv_req_t i_slv_req,
  output logic                   o_rsp_valid,
  output soc_ctrl_pkg::slv_rsp_t o_rsp
);

  localparam int IDX_W = $clog2(`IRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`IRAM_WORDS];
  logic [IDX_W-1:0]       idx;
  logic                   rsp_valid_q;
  soc_ctrl_pkg::slv_rsp_t rsp_q;

  assign idx = i_slv_req.offset[IDX_W-1:0];

  // Answer one cycle after the strobe
  always_ff @(posedge i_clk)
  begin
    rsp_valid_q <= i_sel;
  end

  always_ff @(posedge i_clk)
  begin
    if (i_sel)
    begin
      rsp_q.resp <= soc_bus_pkg::RESP_OKAY;
      if (i_slv_req.op == soc_bus_pkg::OP_WRITE)
      begin
        mem[idx]    <= i_slv_req.wdata;
        rsp_q.rdata <= '0;
      end
      else
      begin
        rsp_q.rdata <= mem[idx];
      end
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;

  // Decoder window must match the RAM depth
  a_offset_range: assert property (@(posedge i_clk)
    i_sel |-> (i_slv_req.offset < `IRAM_WORDS));

endmodule

// File: source/gpio_regs.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module gpio_regs (
  input  logic                   i_clk,
  input  logic                   i_rst_b,
  input  logic                   i_sel,
  input  soc_ctrl_pkg::slv_req_t i_slv_req,
  output logic                   o_rsp_valid,
  output soc_ctrl_pkg::slv_rsp_t o_rsp,
  input  logic [`GPIO_W-1:0]     i_gpio_in,
  output logic [`GPIO_W-1:0]     o_gpio_out
);

  logic [`GPIO_W-1:0]     sync_q1;
  logic [`GPIO_W-1:0]     sync_q2;
  logic [`GPIO_W-1:0]     out_q;
  logic                   rsp_valid_q;
  logic                   is_write;
  soc_ctrl_pkg::slv_rsp_t rsp_q;

  assign is_write = (i_slv_req.op == soc_bus_pkg::OP_WRITE);

  always_ff @(posedge i_clk or negedge i_rst_b)
  begin
    if (!i_rst_b)
    begin
      sync_q1     <= '0;
      sync_q2     <= '0;
      out_q       <= '0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      // Pins are asynchronous to the bus clock
      sync_q1     <= i_gpio_in;
      sync_q2     <= sync_q1;
      rsp_valid_q <= i_sel;
      if (i_sel && is_write && i_slv_req.offset == 10'd0)
      begin
        out_q <= i_slv_req.wdata[`GPIO_W-1:0];
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_sel)
    begin
      rsp_q.resp  <= soc_bus_pkg::RESP_SLVERR;
      rsp_q.rdata <= '0;
      if (i_slv_req.offset == 10'd0)
      begin
        rsp_q.resp <= soc_bus_pkg::RESP_OKAY;
        if (!is_write)
        begin
          rsp_q.rdata <= {{(`SOC_DATA_W - `GPIO_W){1'b0}}, out_q};
        end
      end
      else if (i_slv_req.offset == 10'd1 && !is_write)
      begin
        // Input register is read only
        rsp_q.resp  <= soc_bus_pkg::RESP_OKAY;
        rsp_q.rdata <= {{(`SOC_DATA_W - `GPIO_W){1'b0}}, sync_q2};
      end
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;
  assign o_gpio_out  = out_q;

endmodule

// File: source/sys_timer.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module sys_timer (
  input  logic                   i_clk,
  input  logic                   i_rst_b,
  input  logic                   i_sel,
  input  soc_ctrl_pkg::slv_req_t i_slv_req,
  output logic                   o_rsp_valid,
  output soc_ctrl_pkg::slv_rsp_t o_rsp
);

  logic [63:0]            cnt_q;
  logic [31:0]            hi_q;
  logic                   rsp_valid_q;
  logic                   rd_lo;
  soc_ctrl_pkg::slv_rsp_t rsp_q;

  assign rd_lo = i_sel && i_slv_req.op == soc_bus_pkg::OP_READ && i_slv_req.offset == 10'd0;

  always_ff @(posedge i_clk or negedge i_rst_b)
  begin
    if (!i_rst_b)
    begin
      cnt_q       <= 64'd0;
      hi_q        <= 32'd0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      cnt_q       <= cnt_q + 64'd1;
      rsp_valid_q <= i_sel;
      // Snapshot high half so the pair reads as one value
      if (rd_lo)
      begin
        hi_q <= cnt_q[63:32];
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_sel)
    begin
      rsp_q.resp  <= soc_bus_pkg::RESP_SLVERR;
      rsp_q.rdata <= '0;
      if (rd_lo)
      begin
        rsp_q.resp  <= soc_bus_pkg::RESP_OKAY;
        rsp_q.rdata <= cnt_q[31:0];
      end
      else if (i_slv_req.op == soc_bus_pkg::OP_READ && i_slv_req.offset == 10'd1)
      begin
        rsp_q.resp  <= soc_bus_pkg::RESP_OKAY;
        rsp_q.rdata <= hi_q;
      end
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;

endmodule

// File: source/soc_top.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_top (
  input  logic                  pll_cpu_clk,
  input  logic                  pad_cpu_rst_b,
  input  logic                  i_req_valid,
  output logic                  o_req_ready,
  input  soc_bus_pkg::bus_req_t i_req,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output soc_bus_pkg::bus_rsp_t o_rsp,
  input  logic [`GPIO_W-1:0]    i_gpio_in,
  output logic [`GPIO_W-1:0]    o_gpio_out
);

  soc_ctrl_pkg::slv_req_t slv_req;
  soc_ctrl_pkg::slv_rsp_t iram_rsp;
  soc_ctrl_pkg::slv_rsp_t gpio_rsp;
  soc_ctrl_pkg::slv_rsp_t timer_rsp;
  logic                   iram_sel;
  logic                   gpio_sel;
  logic                   timer_sel;
  logic                   iram_rsp_valid;
  logic                   gpio_rsp_valid;
  logic                   timer_rsp_valid;

  bus_decoder x_bus_decoder (
    .i_clk             (pll_cpu_clk    ),
    .i_rst_b           (pad_cpu_rst_b  ),
    .i_req_valid       (i_req_valid    ),
    .o_req_ready       (o_req_ready    ),
    .i_req             (i_req          ),
    .o_rsp_valid       (o_rsp_valid    ),
    .i_rsp_ready       (i_rsp_ready    ),
    .o_rsp             (o_rsp          ),
    .o_slv_req         (slv_req        ),
    .o_iram_sel        (iram_sel       ),
    .o_gpio_sel        (gpio_sel       ),
    .o_timer_sel       (timer_sel      ),
    .i_iram_rsp        (iram_rsp       ),
    .i_gpio_rsp        (gpio_rsp       ),
    .i_timer_rsp       (timer_rsp      ),
    .i_iram_rsp_valid  (iram_rsp_valid ),
    .i_gpio_rsp_valid  (gpio_rsp_valid ),
    .i_timer_rsp_valid (timer_rsp_valid)
  );

  iram_slave x_iram_slave (
    .i_clk       (pll_cpu_clk   ),
    .i_sel       (iram_sel      ),
    .i_slv_req   (slv_req       ),
    .o_rsp_valid (iram_rsp_valid),
    .o_rsp       (iram_rsp      )
  );

  gpio_regs x_gpio_regs (
    .i_clk       (pll_cpu_clk   ),
    .i_rst_b     (pad_cpu_rst_b ),
    .i_sel       (gpio_sel      ),
    .i_slv_req   (slv_req       ),
    .o_rsp_valid (gpio_rsp_valid),
    .o_rsp       (gpio_rsp      ),
    .i_gpio_in   (i_gpio_in     ),
    .o_gpio_out  (o_gpio_out    )
  );

  sys_timer x_sys_timer (
    .i_clk       (pll_cpu_clk    ),
    .i_rst_b     (pad_cpu_rst_b  ),
    .i_sel       (timer_sel      ),
    .i_slv_req   (slv_req        ),
    .o_rsp_valid (timer_rsp_valid),
    .o_rsp       (timer_rsp      )
  );

endmodule

// File: dv/soc_tb.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_tb;

  localparam int IDX_W          = $clog2(`IRAM_WORDS);
  localparam int N_IRAM         = 24;
  localparam int N_GPIO         = 4;
  localparam int N_TIMER        = 4;
  localparam int N_DECERR       = 6;
  localparam int N_STALL        = 40;
  // Five requests per GPIO round and two per timer round plus a timer write
  localparam int TOTAL_REQS     = 2 * N_IRAM + 5 * N_GPIO + 2 * N_TIMER + 1 + N_DECERR + N_STALL;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20 + 200;
  localparam int KIND_PLAIN     = 0;
  localparam int KIND_TIMER_LO  = 1;
  localparam int KIND_TIMER_HI  = 2;

  logic                   pll_cpu_clk;
  logic                   pad_cpu_rst_b;
  logic                   i_req_valid;
  logic                   o_req_ready;
  soc_bus_pkg::bus_req_t  i_req;
  logic                   o_rsp_valid;
  logic                   i_rsp_ready;
  soc_bus_pkg::bus_rsp_t  o_rsp;
  logic [`GPIO_W-1:0]     i_gpio_in;
  logic [`GPIO_W-1:0]     o_gpio_out;

  logic [`SOC_DATA_W-1:0] shadow_ram [`IRAM_WORDS];
  logic [`GPIO_W-1:0]     gpio_out_model;
  logic [`GPIO_W-1:0]     gpio_in_model;
  logic [IDX_W-1:0]       written_idx [$];
  logic [31:0]            stim_state;
  logic [31:0]            stall_state;
  logic                   stall_en;
  int                     n_errors;

  soc_bus_pkg::bus_rsp_t  exp_q [$];
  int                     kind_q [$];
  string                  name_q [$];
  soc_bus_pkg::bus_rsp_t  exp_rsp;
  soc_bus_pkg::bus_rsp_t  act_rsp;
  int                     exp_kind;
  string                  exp_name;
  logic [31:0]            timer_lo;
  logic [63:0]            timer_pair;
  logic [63:0]            prev_pair;

  soc_top UUT (
    .pll_cpu_clk   (pll_cpu_clk  ),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_req_valid   (i_req_valid  ),
    .o_req_ready   (o_req_ready  ),
    .i_req         (i_req        ),
    .o_rsp_valid   (o_rsp_valid  ),
    .i_rsp_ready   (i_rsp_ready  ),
    .o_rsp         (o_rsp        ),
    .i_gpio_in     (i_gpio_in    ),
    .o_gpio_out    (o_gpio_out   )
  );

  initial
  begin
    pll_cpu_clk = 1'b0;
    forever
    begin
      #10 pll_cpu_clk = ~pll_cpu_clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // Expected response per the address map, without timer data
  function automatic soc_bus_pkg::bus_rsp_t expected_rsp(
    input soc_bus_pkg::bus_req_t req,
    input logic [`GPIO_W-1:0]    gpio_out,
    input logic [`GPIO_W-1:0]    gpio_in
  );
    soc_bus_pkg::bus_rsp_t rsp;
    logic [31:0]           off;
    logic                  is_rd;
    rsp.id    = req.id;
    rsp.resp  = soc_bus_pkg::RESP_DECERR;
    rsp.rdata = '0;
    is_rd     = (req.op == soc_bus_pkg::OP_READ);
    if (req.addr[1:0] == 2'b00)
    begin
      if (req.addr - `IRAM_BASE < `IRAM_WORDS * 4)
      begin
        off      = req.addr - `IRAM_BASE;
        rsp.resp = soc_bus_pkg::RESP_OKAY;
        if (is_rd)
        begin
          rsp.rdata = shadow_ram[off[IDX_W+1:2]];
        end
      end
      else if (req.addr - `GPIO_BASE < `PERIPH_SPAN)
      begin
        off      = req.addr - `GPIO_BASE;
        rsp.resp = soc_bus_pkg::RESP_SLVERR;
        if (off == 32'd0)
        begin
          rsp.resp = soc_bus_pkg::RESP_OKAY;
          if (is_rd)
          begin
            rsp.rdata = {{(`SOC_DATA_W - `GPIO_W){1'b0}}, gpio_out};
          end
        end
        else if (off == 32'd4 && is_rd)
        begin
          rsp.resp  = soc_bus_pkg::RESP_OKAY;
          rsp.rdata = {{(`SOC_DATA_W - `GPIO_W){1'b0}}, gpio_in};
        end
      end
      else if (req.addr - `TIMER_BASE < `PERIPH_SPAN)
      begin
        off      = req.addr - `TIMER_BASE;
        rsp.resp = soc_bus_pkg::RESP_SLVERR;
        if (is_rd && (off == 32'd0 || off == 32'd4))
        begin
          rsp.resp = soc_bus_pkg::RESP_OKAY;
        end
      end
    end
    return rsp;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [63:0] expected,
    input logic [63:0] actual
  );
    if (expected !== actual)
    begin
      n_errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // Starts and ends on a falling edge
  task automatic send_req(
    input string                  name,
    input soc_bus_pkg::bus_op_e   op,
    input logic [`SOC_ADDR_W-1:0] addr,
    input logic [`SOC_DATA_W-1:0] wdata,
    input int                     kind
  );
    soc_bus_pkg::bus_req_t req;
    logic [31:0]           r;
    logic                  accepted;
    r         = next_rand();
    req.op    = op;
    req.id    = r[`SOC_ID_W-1:0];
    req.addr  = addr;
    req.wdata = wdata;
    exp_q.push_back(expected_rsp(req, gpio_out_model, gpio_in_model));
    kind_q.push_back(kind);
    name_q.push_back(name);
    i_req_valid = 1'b1;
    i_req       = req;
    accepted    = 1'b0;
    while (!accepted)
    begin
      // Ready only changes on a rising edge
      accepted = o_req_ready;
      @(negedge pll_cpu_clk);
    end
    i_req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0)
    begin
      @(negedge pll_cpu_clk);
    end
  endtask

  task automatic iram_write(input string name, input logic [IDX_W-1:0] idx);
    logic [31:0] data;
    data = next_rand();
    send_req(name, soc_bus_pkg::OP_WRITE, `IRAM_BASE + (32'(idx) << 2), data, KIND_PLAIN);
    shadow_ram[idx] = data;
    written_idx.push_back(idx);
  endtask

  task automatic iram_read(input string name, input logic [IDX_W-1:0] idx);
    send_req(name, soc_bus_pkg::OP_READ, `IRAM_BASE + (32'(idx) << 2), 32'd0, KIND_PLAIN);
  endtask

  task automatic run_iram_test();
    logic [31:0] r;
    for (int i = 0; i < N_IRAM; i++)
    begin
      r = next_rand();
      iram_write("iram write", r[IDX_W-1:0]);
    end
    for (int i = 0; i < N_IRAM; i++)
    begin
      iram_read("iram read back", written_idx[i]);
    end
  endtask

  task automatic run_gpio_test();
    logic [31:0] r;
    for (int i = 0; i < N_GPIO; i++)
    begin
      r = next_rand();
      send_req("gpio write out", soc_bus_pkg::OP_WRITE, `GPIO_BASE, r, KIND_PLAIN);
      gpio_out_model = r[`GPIO_W-1:0];
      wait_idle();
      check_value("gpio output pins", 64'(gpio_out_model), 64'(o_gpio_out));
      send_req("gpio read out", soc_bus_pkg::OP_READ, `GPIO_BASE, 32'd0, KIND_PLAIN);
      wait_idle();
      r             = next_rand();
      gpio_in_model = r[`GPIO_W-1:0];
      i_gpio_in     = gpio_in_model;
      // Two synchronizer stages plus margin
      repeat (3) @(negedge pll_cpu_clk);
      send_req("gpio read in", soc_bus_pkg::OP_READ, `GPIO_BASE + 32'd4, 32'd0, KIND_PLAIN);
      send_req("gpio write in", soc_bus_pkg::OP_WRITE, `GPIO_BASE + 32'd4, r, KIND_PLAIN);
      send_req("gpio bad offset", soc_bus_pkg::OP_READ, `GPIO_BASE + 32'd8, 32'd0, KIND_PLAIN);
    end
  endtask

  task automatic run_timer_test();
    logic [31:0] r;
    for (int i = 0; i < N_TIMER; i++)
    begin
      r = next_rand();
      send_req("timer read low", soc_bus_pkg::OP_READ, `TIMER_BASE, 32'd0, KIND_TIMER_LO);
      send_req("timer read high", soc_bus_pkg::OP_READ, `TIMER_BASE + 32'd4, 32'd0,
               KIND_TIMER_HI);
      repeat (r[2:0]) @(negedge pll_cpu_clk);
    end
    send_req("timer write", soc_bus_pkg::OP_WRITE, `TIMER_BASE, 32'h1234_5678, KIND_PLAIN);
  endtask

  task automatic run_decerr_test();
    send_req("past iram end", soc_bus_pkg::OP_READ, `IRAM_BASE + `IRAM_WORDS * 4, 32'd0,
             KIND_PLAIN);
    send_req("iram misaligned", soc_bus_pkg::OP_WRITE, `IRAM_BASE + 32'd2, 32'hdead_beef,
             KIND_PLAIN);
    send_req("gpio misaligned", soc_bus_pkg::OP_WRITE, `GPIO_BASE + 32'd1, 32'h0000_00ff,
             KIND_PLAIN);
    send_req("timer misaligned", soc_bus_pkg::OP_READ, `TIMER_BASE + 32'd6, 32'd0, KIND_PLAIN);
    send_req("unmapped high", soc_bus_pkg::OP_READ, 32'h8000_0000, 32'd0, KIND_PLAIN);
    send_req("unmapped gap", soc_bus_pkg::OP_WRITE, `GPIO_BASE + 2 * `PERIPH_SPAN, 32'd7,
             KIND_PLAIN);
  endtask

  task automatic run_stall_test();
    logic [31:0] r;
    int          pick;
    @(posedge pll_cpu_clk);
    stall_en = 1'b1;
    @(negedge pll_cpu_clk);
    for (int i = 0; i < N_STALL; i++)
    begin
      r = next_rand();
      case (r[1:0])
        2'd0:
        begin
          iram_write("stall iram write", r[IDX_W+7:8]);
        end
        2'd1:
        begin
          pick = int'(r[15:8]) % written_idx.size();
          iram_read("stall iram read", written_idx[pick]);
        end
        2'd2:
        begin
          send_req("stall unmapped", soc_bus_pkg::OP_READ,
                   32'h8000_0000 + {20'd0, r[11:2], 2'b00}, 32'd0, KIND_PLAIN);
        end
        default:
        begin
          send_req("stall gpio read", soc_bus_pkg::OP_READ, `GPIO_BASE, 32'd0, KIND_PLAIN);
        end
      endcase
    end
    wait_idle();
  endtask

  // Random stalls on response ready once enabled
  initial
  begin
    i_rsp_ready = 1'b1;
    stall_state = xorshift32(32'd71374 ^ 32'h9e37_79b9);
    forever
    begin
      @(negedge pll_cpu_clk);
      if (stall_en)
      begin
        stall_state = xorshift32(stall_state);
        i_rsp_ready = stall_state[7];
      end
      else
      begin
        i_rsp_ready = 1'b1;
      end
    end
  end

  // Response checker
  always @(posedge pll_cpu_clk)
  begin
    if (pad_cpu_rst_b && o_rsp_valid)
    begin
      check_value("req_ready while response pending", 64'd0, 64'(o_req_ready));
      if (i_rsp_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Error: a response arrived with no request outstanding");
          $display("Verification failed");
          $fatal(1, "unexpected response");
        end
        else
        begin
          exp_rsp  = exp_q.pop_front();
          exp_kind = kind_q.pop_front();
          exp_name = name_q.pop_front();
          act_rsp  = o_rsp;
          if (exp_kind != KIND_PLAIN)
          begin
            exp_rsp.rdata = act_rsp.rdata;
          end
          check_value(exp_name, 64'(exp_rsp), 64'(act_rsp));
          if (exp_kind == KIND_TIMER_LO)
          begin
            timer_lo = act_rsp.rdata;
          end
          else if (exp_kind == KIND_TIMER_HI)
          begin
            timer_pair = {act_rsp.rdata, timer_lo};
            check_value("timer pair increases", 64'd1, 64'(timer_pair > prev_pair));
            prev_pair = timer_pair;
          end
        end
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge pll_cpu_clk);
    $display("Error: timed out after %0d cycles, the DUT stopped answering requests",
             TIMEOUT_CYCLES);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

  initial
  begin
    pad_cpu_rst_b  = 1'b0;
    i_req_valid    = 1'b0;
    i_req          = '0;
    i_gpio_in      = '0;
    stall_en       = 1'b0;
    stim_state     = 32'd71374;
    gpio_out_model = '0;
    gpio_in_model  = '0;
    prev_pair      = 64'd0;
    timer_lo       = 32'd0;
    n_errors       = 0;
    repeat (5) @(posedge pll_cpu_clk);
    @(negedge pll_cpu_clk);
    pad_cpu_rst_b = 1'b1;
    @(negedge pll_cpu_clk);
    check_value("req_ready after reset", 64'd1, 64'(o_req_ready));
    run_iram_test();
    run_gpio_test();
    run_timer_test();
    run_decerr_test();
    run_stall_test();
    wait_idle();
    // Room for a stray extra response to show up
    repeat (4) @(negedge pll_cpu_clk);
    check_value("rsp_valid after drain", 64'd0, 64'(o_rsp_valid));
    check_value("req_ready after drain", 64'd1, 64'(o_req_ready));
    if (n_errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/soc_bus_pkg.sv
source/soc_ctrl_pkg.sv
source/bus_decoder.sv
source/iram_slave.sv
source/gpio_regs.sv
source/sys_timer.sv
source/soc_top.sv
dv/soc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert \
  --top-module soc_tb \
  -f verilog.f \
  --Mdir "$BUILD_DIR" \
  -o soc_tb_sim

"./$BUILD_DIR/soc_tb_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Verification passed" "$LOG"; then
  exit 0
else
  exit 1
fi
